/* Makefile */
VERILATOR := verilator
TOP       := execUnitTb
FILELIST  := files.f
OBJDIR    := obj_dir
FLAGS     := --binary --timing --timescale 1ns/10ps -j 0 --top-module $(TOP) --Mdir $(OBJDIR)
LINTFLAGS := --lint-only --timing --timescale 1ns/10ps --top-module $(TOP)
PASSMSG   := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* dv/execInput.dat */
// columns: instr rs1Val rs2Val pc result writeEn branchTaken branchTarget illegal
// first word is the vector count, result ignored when illegal, target read on branches only
21
002081B3 5 7 1000 C 1 0 0 0
002081B3 FFFFFFFFFFFFFFFF 2 1004 1 1 0 0 0
402081B3 5 7 1008 FFFFFFFFFFFFFFFE 1 0 0 0
0020F1B3 F0F0F0F0F0F0F0F0 FF00FF00FF00FF00 100C F000F000F000F000 1 0 0 0
0020E1B3 F0F0F0F0F0F0F0F0 0F0F00000000FFFF 1010 FFFFF0F0F0F0FFFF 1 0 0 0
0020C1B3 123456789ABCDEF0 FFFFFFFFFFFFFFFF 1014 EDCBA9876543210F 1 0 0 0
00208033 1 1 1018 2 0 0 0 0
00508193 10 DEAD 101C 15 1 0 0 0
FFF08193 0 DEAD 1020 FFFFFFFFFFFFFFFF 1 0 0 0
FF00F193 123456789ABCDEFF DEAD 1024 123456789ABCDEF0 1 0 0 0
0F00E193 F00 DEAD 1028 FF0 1 0 0 0
FFF0C193 FFFFFFFF DEAD 102C FFFFFFFF00000000 1 0 0 0
0020A1B3 8000000000000000 1 1030 1 1 0 0 0
0020A1B3 7FFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 1034 0 1 0 0 0
0020B1B3 1 FFFFFFFFFFFFFFFF 1038 1 1 0 0 0
0020B1B3 FFFFFFFFFFFFFFFF 1 103C 0 1 0 0 0
FFF0A193 8000000000000000 DEAD 1040 1 1 0 0 0
FFF0B193 FFFFFFFFFFFFFFFE DEAD 1044 1 1 0 0 0
00208863 1234 1234 80000000 0 0 1 80000010 0
FE208CE3 1234 1235 80000000 0 0 0 7FFFFFF8 0
00209863 5 5 80000000 0 0 0 80000010 0
FE209CE3 5 6 80000000 0 0 1 7FFFFFF8 0
0020C863 8000000000000000 1 80000000 0 0 1 80000010 0
FE20CCE3 1 FFFFFFFFFFFFFFFF 80000000 0 0 0 7FFFFFF8 0
1020D063 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 1000 0 0 1 1100 0
FE20DCE3 FFFFFFFFFFFFFFFF 0 1000 0 0 0 FF8 0
0020E863 1 FFFFFFFFFFFFFFFF 80000000 0 0 1 80000010 0
FE20ECE3 FFFFFFFFFFFFFFFF 1 80000000 0 0 0 7FFFFFF8 0
0020F863 FFFFFFFFFFFFFFFF 1 80000000 0 0 1 80000010 0
FE20FCE3 0 1 2000 0 0 0 1FF8 0
0000A183 1 2 3000 0 0 0 0 1
022081B3 1 2 3004 0 0 0 0 1
00109193 1 2 3008 0 0 0 0 1

/* dv/execUnitTb.sv */
`timescale 1ns/10ps

module execUnitTb import execPkg::*; ();
    localparam int dataWidth = 64;
    localparam int clkPeriod = 4;
    localparam int latency   = 3;
    localparam int maxVec    = 64;
    localparam int fields    = 9;  // words per vector line

    typedef struct packed {
        logic [31:0]          vecIdx;
        logic [31:0]          instrWord;
        logic [31:0]          issueCycle;  // edge the input was driven after
        logic [dataWidth-1:0] result;
        logic [4:0]           rd;
        logic                 writeEn;
        logic                 taken;
        logic [dataWidth-1:0] target;
        logic                 illegal;
        logic                 isBranch;
    } expectT;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 inValid;
    instrT                instr;
    logic [dataWidth-1:0] rs1Val;
    logic [dataWidth-1:0] rs2Val;
    logic [dataWidth-1:0] pc;
    logic                 outValid;
    logic [dataWidth-1:0] result;
    logic [4:0]           rd;
    logic                 writeEn;
    logic                 branchTaken;
    logic [dataWidth-1:0] branchTarget;
    logic                 illegal;

    logic [dataWidth-1:0] vecMem [0:maxVec*fields];
    expectT               expQ[$];
    expectT               cur;
    int                   numVec;
    int                   cycle = 0;
    int                   passCount;
    int                   failCount;
    int                   errorCount;
    logic                 loaded;
    logic                 vecOk;

    execUnit #(
        .dataWidth (dataWidth)
    ) dut_i (
        .clk          (clk),
        .rst          (rst),
        .inValid      (inValid),
        .instr        (instr),
        .rs1Val       (rs1Val),
        .rs2Val       (rs2Val),
        .pc           (pc),
        .outValid     (outValid),
        .result       (result),
        .rd           (rd),
        .writeEn      (writeEn),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .illegal      (illegal)
    );

    always #(clkPeriod/2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;  // counts rising edges

    task automatic checkResult(input string what, input logic [dataWidth-1:0] got,
                               input logic [dataWidth-1:0] want);
        if (got !== want) begin
            $display("CHECK FAILED at %0d ns: vector %0d %s is %h, expected %h",
                     $time, cur.vecIdx, what, got, want);
            vecOk = 1'b0;
        end
    endtask

    task automatic checkFlag(input string what, input logic got, input logic want);
        if (got !== want) begin
            $display("CHECK FAILED at %0d ns: vector %0d %s is %b, expected %b",
                     $time, cur.vecIdx, what, got, want);
            vecOk = 1'b0;
        end
    endtask

    task automatic checkTarget(input logic [dataWidth-1:0] got, input logic [dataWidth-1:0] want);
        if (got !== want) begin
            $display("CHECK FAILED at %0d ns: vector %0d branchTarget is %h, expected %h",
                     $time, cur.vecIdx, got, want);
            vecOk = 1'b0;
        end
    endtask

    task automatic checkRd(input logic [4:0] got, input logic [4:0] want);
        if (got !== want) begin
            $display("CHECK FAILED at %0d ns: vector %0d rd is %0d, expected %0d",
                     $time, cur.vecIdx, got, want);
            vecOk = 1'b0;
        end
    endtask

    task automatic checkLatency(input int got, input int want);
        if (got != want) begin
            $display("CHECK FAILED at %0d ns: vector %0d came out after %0d cycles, expected %0d",
                     $time, cur.vecIdx, got, want);
            vecOk = 1'b0;
        end
    endtask

    // outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (outValid === 1'b1) begin
            if (expQ.size() == 0) begin
                $display("ERROR at %0d ns: an output appeared with no instruction in flight",
                         $time);
                errorCount++;
            end else begin
                cur = expQ.pop_front();
                vecOk = 1'b1;
                checkLatency(cycle - int'(cur.issueCycle), latency);
                checkFlag("writeEn", writeEn, cur.writeEn);
                checkFlag("branchTaken", branchTaken, cur.taken);
                checkFlag("illegal", illegal, cur.illegal);
                if (!cur.illegal)
                    checkResult("result", result, cur.result);  // undefined when illegal
                if (!cur.illegal && !cur.isBranch)
                    checkRd(rd, cur.rd);
                if (cur.isBranch)
                    checkTarget(branchTarget, cur.target);
                if (vecOk)
                    passCount++;
                else
                    failCount++;
                $display("vector %0d instr %h: %s", cur.vecIdx, cur.instrWord,
                         vecOk ? "ok" : "mismatch");
            end
        end
    end

    initial begin
        int     base;
        int     waitCycles;
        expectT item;
        rst        = 1'b1;
        inValid    = 1'b0;
        instr      = '0;
        rs1Val     = '0;
        rs2Val     = '0;
        pc         = '0;
        passCount  = 0;
        failCount  = 0;
        errorCount = 0;
        loaded     = 1'b0;
        $readmemh("dv/execInput.dat", vecMem);
        numVec = int'(vecMem[0]);  // first word is the count
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        for (int i = 0; i < numVec; i++) begin
            base = 1 + i * fields;
            @(posedge clk);
            #1;
            instr           = vecMem[base][31:0];
            rs1Val          = vecMem[base+1];
            rs2Val          = vecMem[base+2];
            pc              = vecMem[base+3];
            inValid         = 1'b1;
            item.vecIdx     = i;
            item.instrWord  = vecMem[base][31:0];
            item.issueCycle = cycle;
            item.result     = vecMem[base+4];
            item.rd         = vecMem[base][11:7];  // destination field of the encoding
            item.writeEn    = vecMem[base+5][0];
            item.taken      = vecMem[base+6][0];
            item.target     = vecMem[base+7];
            item.illegal    = vecMem[base+8][0];
            item.isBranch   = (instr.rView.opcode == opB) && !item.illegal;
            expQ.push_back(item);
            if (i % 8 == 7) begin
                @(posedge clk);
                #1 inValid = 1'b0;  // idle gap
            end
        end
        @(posedge clk);
        #1 inValid = 1'b0;
        waitCycles = 0;
        while (expQ.size() != 0 && waitCycles < latency + 4) begin
            @(negedge clk);
            waitCycles++;
        end
        repeat (3) @(negedge clk);  // late outputs land as stray
        @(posedge clk);
        if (expQ.size() != 0) begin
            $display("ERROR: %0d instructions never produced an output", expQ.size());
            errorCount++;
        end
        $display("tests: %0d ok, %0d mismatched, %0d other errors",
                 passCount, failCount, errorCount);
        if (failCount == 0 && errorCount == 0 && passCount == numVec)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    // watchdog
    initial begin
        wait (loaded === 1'b1);
        #((numVec + 20) * clkPeriod);
        $display("ERROR: watchdog expired, the run did not finish within %0d cycles",
                 numVec + 20);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* files.f */
source/execPkg.sv
source/execLinks.sv
source/decodeStage.sv
source/aluStage.sv
source/resolveStage.sv
source/execUnit.sv
dv/execUnitTb.sv

/* source/aluStage.sv */
`timescale 1ns/10ps

module aluStage import execPkg::*; #(
    parameter int dataWidth = 64
) (
    input  logic clk,
    input  logic rst,
    decAluIf.dst in,
    aluResIf.src out
);
    logic                 isSub;
    logic [dataWidth-1:0] addend;
    logic [dataWidth-1:0] sum;
    logic [dataWidth-1:0] aluResult;
    logic                 signA;
    logic                 signB;
    logic                 lessThan;
    logic                 unsignedLess;
    cmpFlagsT             flagsNext;

    // compares need the difference as well
    assign isSub = (in.aluOp == aluSub) || (in.aluOp == aluSlt) || (in.aluOp == aluSltu);

    // single adder, subtract via inverted operand and carry in
    assign addend = isSub ? ~in.opB : in.opB;
    assign sum    = in.opA + addend + {{(dataWidth-1){1'b0}}, isSub};

    assign signA = in.opA[dataWidth-1];
    assign signB = in.opB[dataWidth-1];

    // signs differ -> a is less exactly when a is negative
    // otherwise the difference cannot overflow
    assign lessThan     = (signA != signB) ? signA : sum[dataWidth-1];
    assign unsignedLess = in.opA < in.opB;

    always_comb begin
        flagsNext.equal                = ~|sum;
        flagsNext.notEqual             = |sum;
        flagsNext.lessThan             = lessThan;
        flagsNext.greaterEqual         = ~lessThan;
        flagsNext.unsignedLess         = unsignedLess;
        flagsNext.unsignedGreaterEqual = ~unsignedLess;
    end

    always_comb begin
        case (in.aluOp)
            aluAdd,
            aluSub:  aluResult = sum;
            aluAnd:  aluResult = in.opA & in.opB;
            aluOr:   aluResult = in.opA | in.opB;
            aluXor:  aluResult = in.opA ^ in.opB;
            aluSlt:  aluResult = {{(dataWidth-1){1'b0}}, lessThan};
            aluSltu: aluResult = {{(dataWidth-1){1'b0}}, unsignedLess};
            default: aluResult = sum;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out.valid    <= 1'b0;
            out.isBranch <= 1'b0;
            out.isWrite  <= 1'b0;
            out.illegal  <= 1'b0;
        end else begin
            out.valid    <= in.valid;
            out.isBranch <= in.isBranch;
            out.isWrite  <= in.isWrite;
            out.illegal  <= in.illegal;
        end
    end

    // payload forwarded untouched apart from result and flags
    always_ff @(posedge clk) begin
        out.result   <= aluResult;
        out.flags    <= flagsNext;
        out.imm      <= in.imm;
        out.pc       <= in.pc;
        out.rd       <= in.rd;
        out.brFunct3 <= in.brFunct3;
    end

endmodule

/* source/decodeStage.sv */
`timescale 1ns/10ps

module decodeStage import execPkg::*; #(
    parameter int dataWidth = 64
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 inValid,
    input  instrT                instr,
    input  logic [dataWidth-1:0] rs1Val,
    input  logic [dataWidth-1:0] rs2Val,
    input  logic [dataWidth-1:0] pc,
    decAluIf.src                 out
);
    logic [dataWidth-1:0] iImm;
    logic [dataWidth-1:0] bImm;
    aluOpT                f3Op;    // op picked by funct3 alone
    logic                 f3Bad;
    aluOpT                nextOp;
    logic [dataWidth-1:0] nextOpB;
    logic [dataWidth-1:0] nextImm;
    logic                 nextIllegal;
    logic                 nextWrite;
    logic                 nextBranch;

    assign iImm = {{(dataWidth-12){instr.iView.imm12[11]}}, instr.iView.imm12};

    // B offset is scattered over the funct7 and rd slots
    assign bImm = {{(dataWidth-13){instr.rView.funct7[6]}},
                   instr.rView.funct7[6], instr.rView.rd[0],
                   instr.rView.funct7[5:0], instr.rView.rd[4:1], 1'b0};

    // funct3 sits in the same bits for both views
    always_comb begin
        f3Bad = 1'b0;
        case (instr.rView.funct3)
            f3AddSub: f3Op = aluAdd;
            f3Slt:    f3Op = aluSlt;
            f3Sltu:   f3Op = aluSltu;
            f3Xor:    f3Op = aluXor;
            f3Or:     f3Op = aluOr;
            f3And:    f3Op = aluAnd;
            default: begin
                f3Op  = aluAdd;
                f3Bad = 1'b1; // shifts are not supported
            end
        endcase
    end

    always_comb begin
        nextOp      = f3Op;
        nextOpB     = rs2Val;
        nextImm     = iImm;
        nextIllegal = f3Bad;
        nextWrite   = 1'b0;
        nextBranch  = 1'b0;
        case (instr.rView.opcode)
            opR: begin
                nextWrite = 1'b1;
                if (instr.rView.funct7[5] && instr.rView.funct3 == f3AddSub)
                    nextOp = aluSub;
                if (instr.rView.funct7 != f7Base &&
                    !(instr.rView.funct7 == f7Alt && instr.rView.funct3 == f3AddSub))
                    nextIllegal = 1'b1;
            end
            opI: begin
                nextWrite = 1'b1;
                nextOpB   = iImm; // immediate replaces rs2
            end
            opB: begin
                nextBranch  = 1'b1;
                nextImm     = bImm;
                nextIllegal = 1'b0;
                case (instr.rView.funct3)
                    brEq, brNe, brLt, brGe: nextOp = aluSub;
                    brLtu, brGeu:           nextOp = aluSltu; // flag taken from compare
                    default:                nextIllegal = 1'b1;
                endcase
            end
            default: nextIllegal = 1'b1;
        endcase
        if (nextIllegal) begin
            nextWrite  = 1'b0;
            nextBranch = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out.valid    <= 1'b0;
            out.isBranch <= 1'b0;
            out.isWrite  <= 1'b0;
            out.illegal  <= 1'b0;
        end else begin
            out.valid    <= inValid;
            out.isBranch <= nextBranch;
            out.isWrite  <= nextWrite;
            out.illegal  <= nextIllegal;
        end
    end

    always_ff @(posedge clk) begin
        out.aluOp    <= nextOp;
        out.opA      <= rs1Val;
        out.opB      <= nextOpB;
        out.imm      <= nextImm;
        out.pc       <= pc;
        out.rd       <= instr.rView.rd;
        out.brFunct3 <= instr.rView.funct3;
    end

endmodule

/* source/execLinks.sv */
`timescale 1ns/10ps

// decode to alu
interface decAluIf import execPkg::*; #(
    parameter int dataWidth = 64
) ();
    logic                 valid;
    aluOpT                aluOp;
    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;    // rs2 or the sign-extended immediate
    logic [dataWidth-1:0] imm;    // branch offset rides here
    logic [dataWidth-1:0] pc;
    logic [4:0]           rd;
    logic                 isBranch;
    logic                 isWrite;
    logic                 illegal;
    logic [2:0]           brFunct3;

    modport src (output valid, aluOp, opA, opB, imm, pc, rd,
                 isBranch, isWrite, illegal, brFunct3);
    modport dst (input valid, aluOp, opA, opB, imm, pc, rd,
                 isBranch, isWrite, illegal, brFunct3);
endinterface

// alu to resolve
interface aluResIf import execPkg::*; #(
    parameter int dataWidth = 64
) ();
    logic                 valid;
    logic [dataWidth-1:0] result;
    cmpFlagsT             flags;
    logic [dataWidth-1:0] imm;
    logic [dataWidth-1:0] pc;
    logic [4:0]           rd;
    logic                 isBranch;
    logic                 isWrite;
    logic                 illegal;
    logic [2:0]           brFunct3;

    modport src (output valid, result, flags, imm, pc, rd,
                 isBranch, isWrite, illegal, brFunct3);
    modport dst (input valid, result, flags, imm, pc, rd,
                 isBranch, isWrite, illegal, brFunct3);
endinterface

/* source/execPkg.sv */
package execPkg;

    // major opcodes
    localparam logic [6:0] opR = 7'b0110011; // register alu
    localparam logic [6:0] opI = 7'b0010011; // immediate alu
    localparam logic [6:0] opB = 7'b1100011; // conditional branch

    // alu funct3 shared by R and I forms
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // funct7 values accepted on R-type
    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Alt  = 7'b0100000; // bit 5 turns add into sub

    // branch conditions
    localparam logic [2:0] brEq  = 3'b000;
    localparam logic [2:0] brNe  = 3'b001;
    localparam logic [2:0] brLt  = 3'b100;
    localparam logic [2:0] brGe  = 3'b101;
    localparam logic [2:0] brLtu = 3'b110;
    localparam logic [2:0] brGeu = 3'b111;

    typedef enum logic [2:0] {
        aluAdd  = 3'd0,
        aluSub  = 3'd1,
        aluAnd  = 3'd2,
        aluOr   = 3'd3,
        aluXor  = 3'd4,
        aluSlt  = 3'd5,
        aluSltu = 3'd6
    } aluOpT;

    // register layout also used to gather the B-type offset
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rViewT;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iViewT;

    typedef union packed {
        rViewT rView;
        iViewT iView;
    } instrT;

    typedef struct packed {
        logic equal;
        logic notEqual;
        logic lessThan;
        logic greaterEqual;
        logic unsignedLess;
        logic unsignedGreaterEqual;
    } cmpFlagsT;

endpackage

/* source/execUnit.sv */
`timescale 1ns/10ps

module execUnit #(
    parameter int dataWidth = 64
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 inValid,
    input  logic [31:0]          instr,
    input  logic [dataWidth-1:0] rs1Val,
    input  logic [dataWidth-1:0] rs2Val,
    input  logic [dataWidth-1:0] pc,
    output logic                 outValid,
    output logic [dataWidth-1:0] result,
    output logic [4:0]           rd,
    output logic                 writeEn,
    output logic                 branchTaken,
    output logic [dataWidth-1:0] branchTarget,
    output logic                 illegal
);
    // stage links
    decAluIf #(.dataWidth(dataWidth)) decAlu ();
    aluResIf #(.dataWidth(dataWidth)) aluRes ();

    // decode, one cycle
    decodeStage #(
        .dataWidth (dataWidth)
    ) decode (
        .clk     (clk),
        .rst     (rst),
        .inValid (inValid),
        .instr   (instr),
        .rs1Val  (rs1Val),
        .rs2Val  (rs2Val),
        .pc      (pc),
        .out     (decAlu.src)
    );

    aluStage #(
        .dataWidth (dataWidth)
    ) alu (
        .clk (clk),
        .rst (rst),
        .in  (decAlu.dst),
        .out (aluRes.src)
    );

    // branch decision and writeback control
    resolveStage #(
        .dataWidth (dataWidth)
    ) resolve (
        .clk          (clk),
        .rst          (rst),
        .in           (aluRes.dst),
        .outValid     (outValid),
        .result       (result),
        .rd           (rd),
        .writeEn      (writeEn),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .illegal      (illegal)
    );

endmodule

/* source/resolveStage.sv */
`timescale 1ns/10ps

module resolveStage import execPkg::*; #(
    parameter int dataWidth = 64
) (
    input  logic                 clk,
    input  logic                 rst,
    aluResIf.dst                 in,
    output logic                 outValid,
    output logic [dataWidth-1:0] result,
    output logic [4:0]           rd,
    output logic                 writeEn,
    output logic                 branchTaken,
    output logic [dataWidth-1:0] branchTarget,
    output logic                 illegal
);
    logic                 condMet;
    logic [dataWidth-1:0] target;

    // pick the deciding flag
    always_comb begin
        case (in.brFunct3)
            brEq:    condMet = in.flags.equal;
            brNe:    condMet = in.flags.notEqual;
            brLt:    condMet = in.flags.lessThan;
            brGe:    condMet = in.flags.greaterEqual;
            brLtu:   condMet = in.flags.unsignedLess;
            brGeu:   condMet = in.flags.unsignedGreaterEqual;
            default: condMet = 1'b0;
        endcase
    end

    assign target = in.pc + in.imm; // offset is already sign-extended

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid    <= 1'b0;
            writeEn     <= 1'b0;
            branchTaken <= 1'b0;
            illegal     <= 1'b0;
        end else begin
            outValid    <= in.valid;
            writeEn     <= in.valid && in.isWrite && (in.rd != 5'd0); // x0 never written
            branchTaken <= in.valid && in.isBranch && condMet;
            illegal     <= in.valid && in.illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (in.isBranch)
            result <= '0;
        else
            result <= in.result;
        rd           <= in.rd;
        branchTarget <= target;
    end

endmodule
